// ==== csr_config.svh ====
////////////////////
// widths, CSR addresses and reset values of the CSR unit
// counter i sits at CSR_PCCR_BASE + i, base must be 32-aligned
// mtvec is read-only and comes from the boot address
////////////////////

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// bus and datapath widths
`define CSR_ADDR_W 12
`define XLEN 32
`define MTVEC_W 24

// machine trap registers
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MHARTID 12'hF14

// performance counter block
`define CSR_PCER 12'h7A0
`define CSR_PCMR 12'h7A1
`define CSR_PCCR_ALL 12'h79F
`define CSR_PCCR_BASE 12'h780

// mstatus layout, mpp is two bits wide
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LO 11

`define N_PERF_CNT 12
// global enable and saturate both on
`define PCMR_RESET 2'b11

`endif

// ==== csr_bus_pkg.sv ====
////////////////////
// types of the CSR access bus
// access is a level strobe, there is no handshake
////////////////////

`default_nettype none

`include "csr_config.svh"

package csr_bus_pkg;

  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`XLEN-1:0] csr_data_t;

  // operation encoding as issued by the decode stage
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // one request per cycle, valid while access is high
  typedef struct packed {
    logic      access;
    csr_addr_t addr;
    csr_op_e   op;
    csr_data_t wdata;
  } csr_req_t;

endpackage

`default_nettype wire

// ==== core_event_pkg.sv ====
////////////////////
// types of the events the pipeline reports to the CSR unit
// all flags are single-cycle pulses from the controller
////////////////////

`default_nettype none

`include "csr_config.svh"

package core_event_pkg;

  typedef logic [`XLEN-1:0] pc_t;

  // bit 5 set marks an interrupt, bits 4:0 the code
  typedef logic [5:0] cause_t;

  // only the machine-mode enables are kept
  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  typedef struct packed {
    logic   save_cause;
    logic   save_if;
    logic   save_id;
    logic   restore_mret;
    cause_t cause;
    pc_t    pc_if;
    pc_t    pc_id;
  } trap_evt_t;

  // raw pipeline status, qualified inside the counter bank
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic pipeline_stall;
    logic mem_load;
    logic mem_store;
  } perf_evt_t;

endpackage

`default_nettype wire

// ==== csr_bus_decode.sv ====
////////////////////
// bank select, read mux and read-modify-write for the CSR bus
// unmapped addresses read 0 and raise no write strobe
////////////////////

`timescale 1ns/100ps
`default_nettype none

module csr_bus_decode (
  input  csr_bus_pkg::csr_req_t  csr_req_i,
  input  csr_bus_pkg::csr_data_t trap_rdata_i,
  input  csr_bus_pkg::csr_data_t perf_rdata_i,
  input  logic                   trap_hit_i,
  input  logic                   perf_hit_i,
  output csr_bus_pkg::csr_data_t csr_rdata_o,
  output csr_bus_pkg::csr_data_t new_data_o,
  output logic                   trap_we_o,
  output logic                   perf_we_o
);

  import csr_bus_pkg::*;

  logic      trap_sel;
  logic      perf_sel;
  logic      op_active;
  csr_data_t sel_rdata;

  // banks only report address hits, access qualifies them here
  assign trap_sel  = csr_req_i.access & trap_hit_i;
  assign perf_sel  = csr_req_i.access & perf_hit_i;
  assign op_active = (csr_req_i.op != CSR_OP_NONE);

  always_comb begin
    if (trap_sel) begin
      sel_rdata = trap_rdata_i;
    end else if (perf_sel) begin
      sel_rdata = perf_rdata_i;
    end else begin
      sel_rdata = '0;
    end
  end

  assign csr_rdata_o = sel_rdata;

  ////////////////////
  // new value from the old one
  always_comb begin
    case (csr_req_i.op)
      CSR_OP_WRITE: new_data_o = csr_req_i.wdata;
      CSR_OP_SET:   new_data_o = sel_rdata | csr_req_i.wdata;
      CSR_OP_CLEAR: new_data_o = sel_rdata & ~csr_req_i.wdata;
      default:      new_data_o = csr_req_i.wdata;
    endcase
  end

  assign trap_we_o = trap_sel & op_active;
  assign perf_we_o = perf_sel & op_active;

endmodule

`default_nettype wire

// ==== trap_csr_bank.sv ====
////////////////////
// machine trap CSRs: mstatus, mepc, mcause, mtvec, mhartid
// machine mode only, mpp always reads as 2'b11
// mtvec and mhartid ignore writes
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module trap_csr_bank (
  input  logic                      clk,
  input  logic                      rst_n,
  input  csr_bus_pkg::csr_addr_t    addr_i,
  input  csr_bus_pkg::csr_data_t    new_data_i,
  input  logic                      we_i,
  output logic                      hit_o,
  output csr_bus_pkg::csr_data_t    rdata_o,
  input  core_event_pkg::trap_evt_t trap_evt_i,
  input  logic [`MTVEC_W-1:0]       boot_addr_i,
  input  logic [3:0]                core_id_i,
  input  logic [5:0]                cluster_id_i,
  output core_event_pkg::pc_t       epc_o,
  output logic [`MTVEC_W-1:0]       mtvec_o,
  output logic                      m_irq_enable_o
);

  import csr_bus_pkg::*;
  import core_event_pkg::*;

  mstatus_t mstatus_q;
  mstatus_t mstatus_d;
  pc_t      mepc_q;
  pc_t      mepc_d;
  cause_t   mcause_q;
  cause_t   mcause_d;
  pc_t      trap_pc;

  ////////////////////
  // read side
  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (addr_i)
      `CSR_MSTATUS: begin
        rdata_o[`MSTATUS_MIE_BIT]     = mstatus_q.mie;
        rdata_o[`MSTATUS_MPIE_BIT]    = mstatus_q.mpie;
        rdata_o[`MSTATUS_MPP_LO +: 2] = 2'b11;
      end
      `CSR_MTVEC: begin
        rdata_o = {boot_addr_i, {(`XLEN - `MTVEC_W){1'b0}}};
      end
      `CSR_MEPC: begin
        rdata_o = mepc_q;
      end
      `CSR_MCAUSE: begin
        // interrupt flag goes to the top bit
        rdata_o = {mcause_q[5], {(`XLEN - 6){1'b0}}, mcause_q[4:0]};
      end
      `CSR_MHARTID: begin
        rdata_o = {{(`XLEN - 11){1'b0}}, cluster_id_i, 1'b0, core_id_i};
      end
      default: begin
        hit_o = 1'b0;
      end
    endcase
  end

  // pc to save on trap entry, ID stage unless IF is asked for
  assign trap_pc = trap_evt_i.save_if ? trap_evt_i.pc_if : trap_evt_i.pc_id;

  ////////////////////
  // next state
  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    if (we_i) begin
      case (addr_i)
        `CSR_MSTATUS: begin
          mstatus_d.mie  = new_data_i[`MSTATUS_MIE_BIT];
          mstatus_d.mpie = new_data_i[`MSTATUS_MPIE_BIT];
        end
        `CSR_MEPC: begin
          mepc_d = new_data_i;
        end
        `CSR_MCAUSE: begin
          mcause_d = {new_data_i[`XLEN-1], new_data_i[4:0]};
        end
        default: begin
        end
      endcase
    end

    // trap controller overrides a CSR write in the same cycle
    if (trap_evt_i.save_cause) begin
      mepc_d         = trap_pc;
      mcause_d       = trap_evt_i.cause;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
    end else if (trap_evt_i.restore_mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign epc_o          = mepc_q;
  assign mtvec_o        = boot_addr_i;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

`default_nettype wire

// ==== perf_counter_bank.sv ====
////////////////////
// performance counters with PCER enable and PCMR mode
// increments land two edges after the event cycle
// a CSR write to a counter wins over its increment
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module perf_counter_bank (
  input  logic                      clk,
  input  logic                      rst_n,
  input  csr_bus_pkg::csr_addr_t    addr_i,
  input  csr_bus_pkg::csr_data_t    new_data_i,
  input  logic                      we_i,
  output logic                      hit_o,
  output csr_bus_pkg::csr_data_t    rdata_o,
  input  core_event_pkg::perf_evt_t perf_evt_i
);

  import csr_bus_pkg::*;
  import core_event_pkg::*;

  logic                              id_valid_q;
  logic [`N_PERF_CNT-1:0]            evt_in;
  logic [`N_PERF_CNT-1:0]            inc_d;
  logic [`N_PERF_CNT-1:0]            inc_q;
  logic [`N_PERF_CNT-1:0]            pcer_q;
  logic [`N_PERF_CNT-1:0]            pcer_d;
  logic [1:0]                        pcmr_q;
  logic [1:0]                        pcmr_d;
  csr_data_t [`N_PERF_CNT-1:0]       pccr_q;
  csr_data_t [`N_PERF_CNT-1:0]       pccr_d;
  csr_addr_t                         pccr_off;
  logic                              is_pcer;
  logic                              is_pcmr;
  logic                              is_pccr_all;
  logic                              is_pccr_one;

  ////////////////////
  // event sampling
  assign evt_in[0]  = 1'b1;
  assign evt_in[1]  = perf_evt_i.id_valid & perf_evt_i.is_decoding;
  assign evt_in[2]  = perf_evt_i.ld_stall & id_valid_q;
  assign evt_in[3]  = perf_evt_i.jr_stall & id_valid_q;
  // fetch misses not caused by a redirect
  assign evt_in[4]  = perf_evt_i.imiss & ~perf_evt_i.pc_set;
  assign evt_in[5]  = perf_evt_i.mem_load;
  assign evt_in[6]  = perf_evt_i.mem_store;
  assign evt_in[7]  = perf_evt_i.jump & id_valid_q;
  assign evt_in[8]  = perf_evt_i.branch & id_valid_q;
  assign evt_in[9]  = perf_evt_i.branch & perf_evt_i.branch_taken & id_valid_q;
  assign evt_in[10] = perf_evt_i.id_valid & perf_evt_i.is_decoding & perf_evt_i.is_compressed;
  assign evt_in[11] = perf_evt_i.pipeline_stall;

  assign inc_d = evt_in & pcer_q & {`N_PERF_CNT{pcmr_q[0]}};

  ////////////////////
  // address decode and read
  // offset wraps high for addresses below the base
  assign pccr_off    = addr_i - `CSR_PCCR_BASE;
  assign is_pcer     = (addr_i == `CSR_PCER);
  assign is_pcmr     = (addr_i == `CSR_PCMR);
  assign is_pccr_all = (addr_i == `CSR_PCCR_ALL);
  assign is_pccr_one = (pccr_off < csr_addr_t'(`N_PERF_CNT));
  assign hit_o       = is_pcer | is_pcmr | is_pccr_all | is_pccr_one;

  // the all-counter address reads as 0
  always_comb begin
    rdata_o = '0;
    if (is_pcer) begin
      rdata_o[`N_PERF_CNT-1:0] = pcer_q;
    end else if (is_pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end
    for (int i = 0; i < `N_PERF_CNT; i++) begin
      if (is_pccr_one && (pccr_off == csr_addr_t'(i))) begin
        rdata_o = pccr_q[i];
      end
    end
  end

  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (we_i && is_pcer) begin
      pcer_d = new_data_i[`N_PERF_CNT-1:0];
    end
    if (we_i && is_pcmr) begin
      pcmr_d = new_data_i[1:0];
    end
  end

  ////////////////////
  // counter update
  always_comb begin
    for (int i = 0; i < `N_PERF_CNT; i++) begin
      pccr_d[i] = pccr_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && ((pccr_q[i] != '1) || !pcmr_q[1])) begin
        pccr_d[i] = pccr_q[i] + 1'b1;
      end
      if (we_i && (is_pccr_all || (is_pccr_one && (pccr_off == csr_addr_t'(i))))) begin
        pccr_d[i] = new_data_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= `PCMR_RESET;
      pccr_q     <= '0;
    end else begin
      id_valid_q <= perf_evt_i.id_valid;
      inc_q      <= inc_d;
      pcer_q     <= pcer_d;
      pcmr_q     <= pcmr_d;
      pccr_q     <= pccr_d;
    end
  end

endmodule

`default_nettype wire

// ==== csr_unit_top.sv ====
////////////////////
// machine-mode CSR unit, trap bank and counter bank on one bus
// reads are combinational, writes land on the next clk edge
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  csr_bus_pkg::csr_req_t     csr_req_i,
  output csr_bus_pkg::csr_data_t    csr_rdata_o,
  input  core_event_pkg::trap_evt_t trap_evt_i,
  input  core_event_pkg::perf_evt_t perf_evt_i,
  input  logic [`MTVEC_W-1:0]       boot_addr_i,
  input  logic [3:0]                core_id_i,
  input  logic [5:0]                cluster_id_i,
  output core_event_pkg::pc_t       epc_o,
  output logic [`MTVEC_W-1:0]       mtvec_o,
  output logic                      m_irq_enable_o
);

  import csr_bus_pkg::*;
  import core_event_pkg::*;

  csr_data_t trap_rdata;
  csr_data_t perf_rdata;
  csr_data_t new_data;
  logic      trap_hit;
  logic      perf_hit;
  logic      trap_we;
  logic      perf_we;

  csr_bus_decode u_decode (
    .csr_req_i    (csr_req_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .trap_hit_i   (trap_hit),
    .perf_hit_i   (perf_hit),
    .csr_rdata_o  (csr_rdata_o),
    .new_data_o   (new_data),
    .trap_we_o    (trap_we),
    .perf_we_o    (perf_we)
  );

  trap_csr_bank u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (csr_req_i.addr),
    .new_data_i     (new_data),
    .we_i           (trap_we),
    .hit_o          (trap_hit),
    .rdata_o        (trap_rdata),
    .trap_evt_i     (trap_evt_i),
    .boot_addr_i    (boot_addr_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .epc_o          (epc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  perf_counter_bank u_perf (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_i     (csr_req_i.addr),
    .new_data_i (new_data),
    .we_i       (perf_we),
    .hit_o      (perf_hit),
    .rdata_o    (perf_rdata),
    .perf_evt_i (perf_evt_i)
  );

endmodule

`default_nettype wire

// ==== csr_properties.sv ====
////////////////////
// concurrent checks bound into csr_unit_top
// only active with assertions enabled in the simulator
////////////////////

`timescale 1ns/100ps
`default_nettype none

module csr_properties (
  input logic                      clk,
  input logic                      rst_n,
  input csr_bus_pkg::csr_req_t     csr_req_i,
  input core_event_pkg::trap_evt_t trap_evt_i,
  input core_event_pkg::pc_t       epc_i,
  input logic                      m_irq_enable_i,
  input logic                      trap_we_i,
  input logic                      perf_we_i
);

  irq_off_after_trap: assert property (
    @(posedge clk) disable iff (!rst_n)
    trap_evt_i.save_cause |=> !m_irq_enable_i
  ) else $error("interrupt enable still set after trap entry");

  // fetch stage pc saved
  epc_after_if_trap: assert property (
    @(posedge clk) disable iff (!rst_n)
    (trap_evt_i.save_cause && trap_evt_i.save_if) |=> (epc_i == $past(trap_evt_i.pc_if))
  ) else $error("epc does not hold the IF pc");

  // decode stage pc saved
  epc_after_id_trap: assert property (
    @(posedge clk) disable iff (!rst_n)
    (trap_evt_i.save_cause && trap_evt_i.save_id) |=> (epc_i == $past(trap_evt_i.pc_id))
  ) else $error("epc does not hold the ID pc");

  // idle bus never writes a bank, and a write never reaches both banks
  no_strobe_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (trap_we_i || perf_we_i) |-> (csr_req_i.access && !(trap_we_i && perf_we_i))
  ) else $error("write strobe raised without access or to both banks");

endmodule

bind csr_unit_top csr_properties u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .csr_req_i      (csr_req_i),
  .trap_evt_i     (trap_evt_i),
  .epc_i          (epc_o),
  .m_irq_enable_i (m_irq_enable_o),
  .trap_we_i      (trap_we),
  .perf_we_i      (perf_we)
);

`default_nettype wire

// ==== tb_csr_unit.sv ====
////////////////////
// testbench for the CSR unit, checks read back through csr_rdata_o
// inputs change on the falling edge, reads sample 10 ns later
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module tb_csr_unit;

  import csr_bus_pkg::*;
  import core_event_pkg::*;

  logic                clk;
  logic                rst_n;
  csr_req_t            csr_req;
  csr_data_t           csr_rdata;
  trap_evt_t           trap_evt;
  perf_evt_t           perf_evt;
  logic [`MTVEC_W-1:0] boot_addr;
  logic [3:0]          core_id;
  logic [5:0]          cluster_id;
  pc_t                 epc;
  logic [`MTVEC_W-1:0] mtvec;
  logic                m_irq_enable;
  int                  n_checks;
  int                  n_errors;

  csr_unit_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_req_i      (csr_req),
    .csr_rdata_o    (csr_rdata),
    .trap_evt_i     (trap_evt),
    .perf_evt_i     (perf_evt),
    .boot_addr_i    (boot_addr),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .epc_o          (epc),
    .mtvec_o        (mtvec),
    .m_irq_enable_o (m_irq_enable)
  );

  always #50 clk = ~clk;

  task automatic check_word(input string name, input csr_data_t exp, input csr_data_t act);
    n_checks++;
    assert (act == exp) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  // got must lie within tol of exp
  task automatic check_count(input string name, input csr_data_t got, input int exp,
                             input int tol);
    n_checks++;
    assert ((got + tol >= exp) && (got <= exp + tol)) else begin
      $display("[ERROR] %0t %s expected %0d +/- %0d got %0d", $time, name, exp, tol, got);
      n_errors++;
    end
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    @(negedge clk);
    csr_req.access = 1'b1;
    csr_req.addr   = addr;
    csr_req.op     = CSR_OP_NONE;
    #10;
    data = csr_rdata;
  endtask

  task automatic read_check(input csr_addr_t addr, input csr_data_t exp, input string name);
    csr_data_t rd;
    csr_read(addr, rd);
    check_word(name, exp, rd);
  endtask

  task automatic csr_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata);
    @(negedge clk);
    csr_req.access = 1'b1;
    csr_req.addr   = addr;
    csr_req.op     = op;
    csr_req.wdata  = wdata;
    @(negedge clk);
    csr_req.access = 1'b0;
    csr_req.op     = CSR_OP_NONE;
  endtask

  // write, set and clear as the CSR bus defines them
  function automatic csr_data_t apply_op(csr_op_e op, csr_data_t old, csr_data_t wdata);
    case (op)
      CSR_OP_SET:   return old | wdata;
      CSR_OP_CLEAR: return old & ~wdata;
      default:      return wdata;
    endcase
  endfunction

  function automatic csr_op_e pick_op();
    case ($urandom % 3)
      0:       return CSR_OP_WRITE;
      1:       return CSR_OP_SET;
      default: return CSR_OP_CLEAR;
    endcase
  endfunction

  task automatic rmw_run(input csr_addr_t addr, input csr_data_t mask, input string name);
    csr_data_t model;
    csr_data_t wdata;
    csr_op_e   op;
    csr_read(addr, model);
    for (int k = 0; k < 8; k++) begin
      op    = pick_op();
      wdata = $urandom;
      model = apply_op(op, model, wdata) & mask;
      csr_access(op, addr, wdata);
      read_check(addr, model, name);
    end
  endtask

  // optional mepc write lands in the same cycle as the trap
  task automatic trap_entry(input logic from_if, input cause_t cause, input pc_t pc_if,
                            input pc_t pc_id, input logic with_write, input csr_data_t wdata);
    @(negedge clk);
    trap_evt.save_cause = 1'b1;
    trap_evt.save_if    = from_if;
    trap_evt.save_id    = ~from_if;
    trap_evt.cause      = cause;
    trap_evt.pc_if      = pc_if;
    trap_evt.pc_id      = pc_id;
    if (with_write) begin
      csr_req.access = 1'b1;
      csr_req.addr   = `CSR_MEPC;
      csr_req.op     = CSR_OP_WRITE;
      csr_req.wdata  = wdata;
    end
    @(negedge clk);
    trap_evt.save_cause = 1'b0;
    csr_req.access      = 1'b0;
    csr_req.op          = CSR_OP_NONE;
  endtask

  task automatic wait_irq_enable(input logic value, input int limit);
    int cycles;
    cycles = 0;
    while ((m_irq_enable !== value) && (cycles < limit)) begin
      @(negedge clk);
      cycles++;
    end
    if (m_irq_enable !== value) begin
      $display("timeout at %0t: m_irq_enable_o never became %0b", $time, value);
      n_errors++;
    end
  endtask

  // counter 0 must not move over a few cycles
  task automatic hold_check(input string name);
    csr_data_t h0;
    csr_data_t h1;
    @(negedge clk);
    csr_read(`CSR_PCCR_BASE, h0);
    repeat (5) @(negedge clk);
    csr_read(`CSR_PCCR_BASE, h1);
    check_word(name, h0, h1);
  endtask

  initial begin
    csr_data_t c0;
    csr_data_t c1;
    pc_t       pc_a;
    void'($urandom(32'h2bd2));
    clk        = 1'b0;
    rst_n      = 1'b0;
    csr_req    = '0;
    trap_evt   = '0;
    perf_evt   = '0;
    boot_addr  = 24'h1C_0080;
    core_id    = 4'h5;
    cluster_id = 6'h2A;
    n_checks   = 0;
    n_errors   = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    ////////////////////
    // reset values and hart id
    read_check(`CSR_MSTATUS, 32'h0000_1800, "mstatus");
    read_check(`CSR_PCMR, 32'd3, "pcmr");
    read_check(`CSR_PCER, 32'd0, "pcer");
    read_check(`CSR_MHARTID, (csr_data_t'(cluster_id) << 5) | csr_data_t'(core_id), "mhartid");
    read_check(12'h123, 32'd0, "unmapped");

    rmw_run(`CSR_MEPC, 32'hFFFF_FFFF, "mepc");
    rmw_run(`CSR_MCAUSE, 32'h8000_001F, "mcause");

    ////////////////////
    // trap entry, mret and mtvec
    csr_access(CSR_OP_SET, `CSR_MSTATUS, 32'h0000_0008);
    read_check(`CSR_MSTATUS, 32'h0000_1808, "mstatus");
    pc_a = $urandom;
    trap_entry(1'b1, 6'h27, pc_a, $urandom, 1'b0, '0);
    wait_irq_enable(1'b0, 4);
    check_word("epc_o", pc_a, epc);
    read_check(`CSR_MEPC, pc_a, "mepc");
    read_check(`CSR_MCAUSE, 32'h8000_0007, "mcause");
    read_check(`CSR_MSTATUS, 32'h0000_1880, "mstatus");
    @(negedge clk);
    trap_evt.restore_mret = 1'b1;
    @(negedge clk);
    trap_evt.restore_mret = 1'b0;
    wait_irq_enable(1'b1, 4);
    read_check(`CSR_MSTATUS, 32'h0000_1888, "mstatus");
    read_check(`CSR_MTVEC, csr_data_t'(boot_addr) << 8, "mtvec");
    check_word("mtvec_o", csr_data_t'(boot_addr), csr_data_t'(mtvec));

    // trap wins over a same-cycle mepc write
    pc_a = $urandom;
    trap_entry(1'b0, 6'h02, $urandom, pc_a, 1'b1, ~pc_a);
    read_check(`CSR_MEPC, pc_a, "mepc");
    read_check(`CSR_MCAUSE, 32'h0000_0002, "mcause");

    ////////////////////
    // cycle counter, N posedges between the two samples
    csr_access(CSR_OP_WRITE, `CSR_PCCR_BASE, 32'd0);
    csr_access(CSR_OP_WRITE, `CSR_PCER, 32'd1);
    csr_read(`CSR_PCCR_BASE, c0);
    repeat (9) @(negedge clk);
    csr_read(`CSR_PCCR_BASE, c1);
    check_count("pccr0 delta", c1 - c0, 10, 1);
    csr_access(CSR_OP_WRITE, `CSR_PCER, 32'd0);
    hold_check("pccr0 with pcer 0");
    csr_access(CSR_OP_WRITE, `CSR_PCER, 32'd1);
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'd0);
    hold_check("pccr0 with pcmr 0");

    // saturation, then wrap once it is off
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'd3);
    csr_access(CSR_OP_WRITE, `CSR_PCCR_ALL, 32'hFFFF_FFFF);
    repeat (4) @(negedge clk);
    read_check(`CSR_PCCR_BASE, 32'hFFFF_FFFF, "pccr0");
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'd1);
    repeat (3) @(negedge clk);
    csr_read(`CSR_PCCR_BASE, c1);
    check_count("pccr0", c1, 3, 1);

    csr_req.access = 1'b0;
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
csr_bus_pkg.sv
core_event_pkg.sv
csr_bus_decode.sv
trap_csr_bank.sv
perf_counter_bank.sv
csr_unit_top.sv
csr_properties.sv
tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

sim_out="$(verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_csr_unit 2>&1 && ./obj_dir/Vtb_csr_unit 2>&1)"
echo "$sim_out"

grep -qF '*** PASSED ***' <<< "$sim_out" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
